// ==== design/cdc_defines.svh ====
`ifndef CDC_DEFINES_SVH
`define CDC_DEFINES_SVH

////////////////////////////////////////
// bridge sizing
////////////////////////////////////////

// bits per transferred word
`define CDC_DATA_WIDTH 16

// flops per level synchronizer
`define CDC_SYNC_DEPTH 2

`endif

// ==== design/cdcPkg.sv ====
`include "cdc_defines.svh"

package cdcPkg;

	// one word carried across the bridge
	typedef logic [`CDC_DATA_WIDTH-1:0] xferWord_t;

	// phase of a four-phase req/ack handshake
	// shared by both stages so the state names line up
	typedef enum logic [1:0]
	{
		// waiting for a request
		phIdle,
		// request raised, no ack yet
		phRequest,
		// ack given, waiting for request to drop
		phAcknowledge,
		// request dropped, waiting for ack to drop
		phRelease
	} hsPhase_t;

endpackage

// ==== design/levelSync.sv ====
`timescale 1ns/10ps
`include "cdc_defines.svh"

module levelSync #(
	parameter int DEPTH = `CDC_SYNC_DEPTH
)(
	input  logic clk,
	input  logic ackI,
	input  logic level,
	output logic synced
);

	// flop chain in the receiving domain
	// bit 0 is the metastable capture flop
	logic [DEPTH-1:0] syncChain;

	always_ff @(posedge clk or posedge ackI)
	begin
		if (ackI)
			syncChain <= '0;
		else
		begin
			syncChain[0] <= level;
			// shift toward the output end
			for (int i = 1; i < DEPTH; i++)
				syncChain[i] <= syncChain[i-1];
		end
	end

	// last flop drives the synced level
	assign synced = syncChain[DEPTH-1];

	////////////////////////////////////////
	// checks
	////////////////////////////////////////

	// output only moves to what the input held DEPTH edges back
	assert property (@(posedge clk) disable iff (ackI)
		$changed(synced) |-> (synced == $past(level, DEPTH)))
	else
		$error("levelSync output changed to a value the input never held");

endmodule

// ==== design/srcCapture.sv ====
`timescale 1ns/10ps

module srcCapture
	import cdcPkg::*;
(
	input  logic      clkStb,
	input  logic      ackI,
	// producer handshake
	input  logic      inReq,
	input  xferWord_t inData,
	output logic      inAck,
	// crossing handshake
	input  logic      xAckSync,
	output logic      xReq,
	output xferWord_t xData
);

	hsPhase_t  prodState;
	hsPhase_t  xState;
	logic      holdFull;
	xferWord_t holdData;
	logic      latchWord;
	logic      freeHold;

	// accept only with the holding register empty
	assign latchWord = (prodState == phIdle) && inReq && !holdFull;
	// crossing finished once returned ack is low again
	assign freeHold = (xState == phRelease) && !xAckSync;

	////////////////////////////////////////
	// producer side
	////////////////////////////////////////

	always_ff @(posedge clkStb or posedge ackI)
	begin
		if (ackI)
		begin
			prodState <= phIdle;
			inAck <= 1'b0;
		end
		else
		begin
			case (prodState)
				phIdle:
				begin
					// ack goes up with the latch
					if (latchWord)
					begin
						prodState <= phAcknowledge;
						inAck <= 1'b1;
					end
				end
				phAcknowledge:
				begin
					// producer let go of req
					if (!inReq)
					begin
						prodState <= phIdle;
						inAck <= 1'b0;
					end
				end
				default:
				begin
					prodState <= phIdle;
					inAck <= 1'b0;
				end
			endcase
		end
	end

	// held word, payload only
	always_ff @(posedge clkStb)
	begin
		if (latchWord)
			holdData <= inData;
	end

	// full flag set by producer side, cleared by crossing side
	always_ff @(posedge clkStb or posedge ackI)
	begin
		if (ackI)
			holdFull <= 1'b0;
		else if (latchWord)
			holdFull <= 1'b1;
		else if (freeHold)
			holdFull <= 1'b0;
	end

	////////////////////////////////////////
	// crossing side
	////////////////////////////////////////

	always_ff @(posedge clkStb or posedge ackI)
	begin
		if (ackI)
		begin
			xState <= phIdle;
			xReq <= 1'b0;
		end
		else
		begin
			case (xState)
				phIdle:
				begin
					// one edge after the latch
					if (holdFull)
					begin
						xState <= phRequest;
						xReq <= 1'b1;
					end
				end
				phRequest:
				begin
					// far side has the word
					if (xAckSync)
					begin
						xState <= phRelease;
						xReq <= 1'b0;
					end
				end
				phRelease:
				begin
					if (freeHold)
						xState <= phIdle;
				end
				default:
				begin
					xState <= phIdle;
					xReq <= 1'b0;
				end
			endcase
		end
	end

	// bus held steady from latch until freed
	assign xData = holdData;

	////////////////////////////////////////
	// checks
	////////////////////////////////////////

	// crossing bus frozen while the request is out
	assert property (@(posedge clkStb) disable iff (ackI)
		xReq |=> $stable(xData))
	else
		$error("xData moved while xReq was high");

	// ack only answers a request seen on the edge before
	assert property (@(posedge clkStb) disable iff (ackI)
		$rose(inAck) |-> $past(inReq))
	else
		$error("inAck rose without inReq");

endmodule

// ==== design/dstRelease.sv ====
`timescale 1ns/10ps

module dstRelease
	import cdcPkg::*;
(
	input  logic      clkAck,
	input  logic      ackI,
	// crossing handshake
	input  logic      xReqSync,
	input  xferWord_t xData,
	output logic      xAck,
	// consumer handshake
	output logic      outReq,
	output xferWord_t outData,
	input  logic      outAck
)
;

	hsPhase_t xState;
	hsPhase_t outState;
	logic     loadWord;

	// new request, empty output register, consumer quiet
	assign loadWord = (xState == phIdle) && xReqSync
		&& (outState == phIdle) && !outAck;

	////////////////////////////////////////
	// crossing side
	////////////////////////////////////////

	always_ff @(posedge clkAck or posedge ackI)
	begin
		if (ackI)
		begin
			xState <= phIdle;
			xAck <= 1'b0;
		end
		else
		begin
			case (xState)
				phIdle:
				begin
					if (loadWord)
					begin
						xState <= phAcknowledge;
						xAck <= 1'b1;
					end
				end
				phAcknowledge:
				begin
					// source saw the ack and dropped req
					if (!xReqSync)
					begin
						xState <= phIdle;
						xAck <= 1'b0;
					end
				end
				default:
				begin
					xState <= phIdle;
					xAck <= 1'b0;
				end
			endcase
		end
	end

	// output register, payload only
	// xData has sat still for a full sync delay by now
	always_ff @(posedge clkAck)
	begin
		if (loadWord)
			outData <= xData;
	end

	////////////////////////////////////////
	// consumer side
	////////////////////////////////////////

	// any state but idle means the output register is full
	always_ff @(posedge clkAck or posedge ackI)
	begin
		if (ackI)
		begin
			outState <= phIdle;
			outReq <= 1'b0;
		end
		else
		begin
			case (outState)
				phIdle:
				begin
					// offer the word on the load edge
					if (loadWord)
					begin
						outState <= phRequest;
						outReq <= 1'b1;
					end
				end
				phRequest:
				begin
					if (outAck)
					begin
						outState <= phRelease;
						outReq <= 1'b0;
					end
				end
				phRelease:
				begin
					// empty once consumer drops ack
					if (!outAck)
						outState <= phIdle;
				end
				default:
				begin
					outState <= phIdle;
					outReq <= 1'b0;
				end
			endcase
		end
	end

	////////////////////////////////////////
	// checks
	////////////////////////////////////////

	// consumer sees a steady word for the whole request
	assert property (@(posedge clkAck) disable iff (ackI)
		outReq |=> $stable(outData))
	else
		$error("outData moved while outReq was high");

	// no new request on top of a live ack
	assert property (@(posedge clkAck) disable iff (ackI)
		$rose(outReq) |-> !$past(outAck))
	else
		$error("outReq rose while outAck was high");

endmodule

// ==== design/cdcBridge.sv ====
`timescale 1ns/10ps

module cdcBridge
	import cdcPkg::*;
(
	input  logic      clkStb,
	input  logic      clkAck,
	input  logic      ackI,
	// producer side, clkStb domain
	input  logic      inReq,
	input  xferWord_t inData,
	output logic      inAck,
	// consumer side, clkAck domain
	output logic      outReq,
	output xferWord_t outData,
	input  logic      outAck
);

	// crossing request and its clkAck copy
	logic      xReq;
	logic      xReqSync;
	// crossing ack and its clkStb copy
	logic      xAck;
	logic      xAckSync;
	// held word, only sampled after the request settles
	xferWord_t xData;

	////////////////////////////////////////
	// source stage
	////////////////////////////////////////

	srcCapture srcStage (
		.clkStb   (clkStb),
		.ackI     (ackI),
		.inReq    (inReq),
		.inData   (inData),
		.inAck    (inAck),
		.xAckSync (xAckSync),
		.xReq     (xReq),
		.xData    (xData)
	);

	////////////////////////////////////////
	// level crossings
	////////////////////////////////////////

	// request into clkAck
	levelSync reqSync (
		.clk    (clkAck),
		.ackI   (ackI),
		.level  (xReq),
		.synced (xReqSync)
	);

	// ack back into clkStb
	levelSync ackSync (
		.clk    (clkStb),
		.ackI   (ackI),
		.level  (xAck),
		.synced (xAckSync)
	);

	////////////////////////////////////////
	// destination stage
	////////////////////////////////////////

	dstRelease dstStage (
		.clkAck   (clkAck),
		.ackI     (ackI),
		.xReqSync (xReqSync),
		.xData    (xData),
		.xAck     (xAck),
		.outReq   (outReq),
		.outData  (outData),
		.outAck   (outAck)
	);

endmodule

// ==== sim/cdcBridgeTb.sv ====
`timescale 1ns/10ps

module cdcBridgeTb
	import cdcPkg::*;
();

	localparam int TABLE_LEN = 16;
	// 20 ns and 34 ns periods never share a rising edge
	localparam int STB_HALF = 10;
	localparam int ACK_HALF = 17;
	// cycles of the sampling clock per wait
	localparam int WAIT_LIMIT = 400;

	logic      clkStb;
	logic      clkAck;
	logic      ackI;
	logic      inReq;
	xferWord_t inData;
	logic      inAck;
	logic      outReq;
	xferWord_t outData;
	logic      outAck;

	// stimulus table of words and consumer stalls
	xferWord_t tblData [TABLE_LEN];
	int        tblStall [TABLE_LEN];
	// words sent but not yet seen at the consumer
	xferWord_t expQ [$];

	int        errCount;
	int        seed;
	int        accepted;
	int        popped;
	bit        timedOut;
	logic      prevInReq;
	logic      prevInAck;
	logic      prevOutReq;
	logic      prevOutAck;
	xferWord_t prevOutData;

	cdcBridge dut (
		.clkStb  (clkStb),
		.clkAck  (clkAck),
		.ackI    (ackI),
		.inReq   (inReq),
		.inData  (inData),
		.inAck   (inAck),
		.outReq  (outReq),
		.outData (outData),
		.outAck  (outAck)
	);

	////////////////////////////////////////
	// clocks
	////////////////////////////////////////

	initial clkStb = 1'b0;
	always #STB_HALF clkStb = ~clkStb;

	initial clkAck = 1'b0;
	always #ACK_HALF clkAck = ~clkAck;

	////////////////////////////////////////
	// table and reset helpers
	////////////////////////////////////////

	task automatic fillTable();
		// fixed corner patterns first
		tblData[0] = 16'h0000;
		tblStall[0] = 0;
		tblData[1] = 16'hFFFF;
		tblStall[1] = 3;
		tblData[2] = 16'hAAAA;
		tblStall[2] = 0;
		tblData[3] = 16'h5555;
		tblStall[3] = 6;
		tblData[4] = 16'h00FF;
		tblStall[4] = 1;
		tblData[5] = 16'hFF00;
		tblStall[5] = 0;
		tblData[6] = 16'h1234;
		tblStall[6] = 9;
		tblData[7] = 16'h8001;
		tblStall[7] = 2;
		// rest from the seeded generator
		for (int i = 8; i < TABLE_LEN; i++)
		begin
			tblData[i] = xferWord_t'($random(seed));
			tblStall[i] = int'({$random(seed)} % 5);
		end
	endtask

	// both handshake outputs must sit low
	task automatic checkIdle(input string phase);
		assert (inAck === 1'b0)
		else
		begin
			errCount++;
			$display("** Error at %0t ns: inAck is %b %s", $time, inAck, phase);
		end
		assert (outReq === 1'b0)
		else
		begin
			errCount++;
			$display("** Error at %0t ns: outReq is %b %s", $time, outReq, phase);
		end
	endtask

	////////////////////////////////////////
	// producer
	////////////////////////////////////////

	task automatic sendWord(input xferWord_t word);
		int waitCount;
		@(negedge clkStb);
		expQ.push_back(word);
		inData = word;
		inReq = 1'b1;
		waitCount = 0;
		while (inAck !== 1'b1 && !timedOut)
		begin
			@(negedge clkStb);
			waitCount++;
			if (waitCount > WAIT_LIMIT)
			begin
				$display("Timeout: inAck never went high for word %h", word);
				errCount++;
				timedOut = 1'b1;
			end
		end
		inReq = 1'b0;
		waitCount = 0;
		// four-phase return to zero
		while (inAck !== 1'b0 && !timedOut)
		begin
			@(negedge clkStb);
			waitCount++;
			if (waitCount > WAIT_LIMIT)
			begin
				$display("Timeout: inAck never went low after inReq dropped");
				errCount++;
				timedOut = 1'b1;
			end
		end
	endtask

	task automatic runProducer();
		for (int i = 0; i < TABLE_LEN && !timedOut; i++)
			sendWord(tblData[i]);
	endtask

	////////////////////////////////////////
	// consumer with stalls
	////////////////////////////////////////

	task automatic runConsumer();
		xferWord_t expWord;
		xferWord_t heldWord;
		int        waitCount;
		for (int i = 0; i < TABLE_LEN && !timedOut; i++)
		begin
			waitCount = 0;
			while (outReq !== 1'b1 && !timedOut)
			begin
				@(negedge clkAck);
				waitCount++;
				if (waitCount > WAIT_LIMIT)
				begin
					$display("Timeout: outReq never went high for word %0d", i);
					errCount++;
					timedOut = 1'b1;
				end
			end
			if (!timedOut)
			begin
				heldWord = outData;
				// word must stay offered through the stall
				repeat (tblStall[i])
				begin
					@(negedge clkAck);
					assert (outReq === 1'b1 && outData === heldWord)
					else
					begin
						errCount++;
						$display("** Error at %0t ns: stall on word %0d, outReq %b data %h held %h",
							$time, i, outReq, outData, heldWord);
					end
				end
				if (expQ.size() == 0)
				begin
					$display("Consumer got word %h with nothing left to expect", outData);
					errCount++;
				end
				else
				begin
					expWord = expQ.pop_front();
					popped++;
					assert (outData === expWord)
					else
					begin
						errCount++;
						$display("** Error at %0t ns: word %0d expected %h received %h",
							$time, i, expWord, outData);
					end
				end
				outAck = 1'b1;
				waitCount = 0;
				while (outReq !== 1'b0 && !timedOut)
				begin
					@(negedge clkAck);
					waitCount++;
					if (waitCount > WAIT_LIMIT)
					begin
						$display("Timeout: outReq never went low after outAck rose");
						errCount++;
						timedOut = 1'b1;
					end
				end
				outAck = 1'b0;
			end
		end
	endtask

	////////////////////////////////////////
	// protocol monitors
	////////////////////////////////////////

	// compares pre-edge values against those of the edge before
	always @(posedge clkStb)
	begin
		if (ackI)
		begin
			prevInReq = 1'b0;
			prevInAck = 1'b0;
		end
		else
		begin
			if (inAck && !prevInAck)
			begin
				accepted++;
				assert (prevInReq)
				else
				begin
					errCount++;
					$display("** Error at %0t ns: inAck rose while inReq was low", $time);
				end
				// at most the held word and the output word
				assert (accepted - popped <= 2)
				else
				begin
					errCount++;
					$display("** Error at %0t ns: %0d words outstanding", $time,
						accepted - popped);
				end
			end
			if (!inAck && prevInAck)
				assert (!prevInReq)
				else
				begin
					errCount++;
					$display("** Error at %0t ns: inAck fell while inReq was high", $time);
				end
			prevInReq = inReq;
			prevInAck = inAck;
		end
	end

	always @(posedge clkAck)
	begin
		if (ackI)
		begin
			prevOutReq = 1'b0;
			prevOutAck = 1'b0;
			prevOutData = '0;
		end
		else
		begin
			if (outReq && !prevOutReq)
				assert (!prevOutAck)
				else
				begin
					errCount++;
					$display("** Error at %0t ns: outReq rose while outAck was high", $time);
				end
			if (!outReq && prevOutReq)
				assert (prevOutAck)
				else
				begin
					errCount++;
					$display("** Error at %0t ns: outReq fell without outAck", $time);
				end
			if (outReq && prevOutReq)
				assert (outData === prevOutData)
				else
				begin
					errCount++;
					$display("** Error at %0t ns: outData moved from %h to %h",
						$time, prevOutData, outData);
				end
			prevOutReq = outReq;
			prevOutAck = outAck;
			prevOutData = outData;
		end
	end

	////////////////////////////////////////
	// main sequence
	////////////////////////////////////////

	initial
	begin
		$timeformat(-9, 0, "", 0);
		errCount = 0;
		seed = 36;
		accepted = 0;
		popped = 0;
		timedOut = 1'b0;
		ackI = 1'b1;
		inReq = 1'b0;
		inData = '0;
		outAck = 1'b0;
		fillTable();
		repeat (5)
		begin
			@(negedge clkStb);
			checkIdle("during reset");
		end
		// release clear of both clock edges
		#4;
		ackI = 1'b0;
		@(negedge clkStb);
		checkIdle("after reset");
		fork
			runProducer();
			runConsumer();
		join
		if (!timedOut && (expQ.size() != 0 || popped != TABLE_LEN))
		begin
			$display("Only %0d of %0d words reached the consumer", popped, TABLE_LEN);
			errCount++;
		end
		// a duplicate would show up as a late request
		repeat (20)
		begin
			@(negedge clkAck);
			assert (outReq === 1'b0)
			else
			begin
				errCount++;
				$display("** Error at %0t ns: outReq high after the last word", $time);
			end
		end
		$display("Errors: %0d", errCount);
		if (errCount == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

// ==== build.f ====
+incdir+design
design/cdcPkg.sv
design/levelSync.sv
design/srcCapture.sv
design/dstRelease.sv
design/cdcBridge.sv
sim/cdcBridgeTb.sv
